/* bench/uiq_golden.txt */
# D acc pc opcode funct3 funct7 imm src1_preg src2_preg dest_preg src1_rdy src2_rdy
#   src1_data src2_data then expected tag alu op src1 src2, all hex
# B preg data, A alu_ready, I cycles waiting, S stall level, W test number
A 7
# test 1 decode of the ten operations and implied operands
D 1 100 33 0 00 0 01 02 10 1 1 11 22 00 0 1 11 22
D 1 104 13 0 00 5 03 00 11 1 0 33 44 01 1 2 33 0
D 1 108 37 0 00 12345000 04 05 12 0 0 55 66 02 2 3 0 0
D 1 10c 13 6 00 f0 06 07 13 1 1 77 88 03 0 4 77 0
D 1 110 33 4 00 0 08 09 14 1 1 99 aa 04 1 5 99 aa
D 1 114 13 5 20 3 0a 0b 15 1 1 bb cc 05 2 6 bb 0
D 1 118 03 0 00 8 0c 0d 16 1 1 dd ee 06 0 7 dd 0
D 1 11c 03 2 00 c 0e 0f 17 1 1 ff 1ff 07 1 8 ff 0
D 1 120 23 0 00 4 10 11 18 1 1 123 456 08 2 9 123 456
D 1 124 23 2 00 0 12 13 19 1 1 789 abc 09 0 a 789 abc
W 1
# test 2 round robin carries on past rejected encodings
D 1 128 33 0 00 0 14 15 1a 1 1 1000 2000 0a 1 1 1000 2000
D 0 12c 63 0 00 0 16 17 1b 1 1 1 2 00 0 0 0 0
D 0 130 33 0 20 0 18 19 1c 1 1 3 4 00 0 0 0 0
D 1 134 33 4 00 0 1a 1b 1d 1 1 5555 aaaa 0b 2 5 5555 aaaa
W 2
# test 3 wakeup
D 1 200 33 0 00 0 20 21 22 1 0 7 0 0c 0 1 7 abcd
I 4 1
B 21 abcd
W 3
# test 4 alu 1 held back
A 5
D 1 300 33 0 00 0 01 02 23 1 1 31 32 0d 1 1 31 32
D 1 304 33 0 00 0 01 02 24 1 1 41 42 0e 2 1 41 42
D 1 308 33 0 00 0 01 02 25 1 1 51 52 0f 0 1 51 52
D 1 30c 33 0 00 0 01 02 26 1 1 61 62 10 1 1 61 62
I 4 2
A 7
W 4
# test 5 full queue
A 0
D 1 400 33 0 00 0 01 02 30 1 1 a0 b0 11 2 1 a0 b0
D 1 404 33 0 00 0 01 02 31 1 1 a1 b1 12 0 1 a1 b1
D 1 408 33 0 00 0 01 02 32 1 1 a2 b2 13 1 1 a2 b2
D 1 40c 33 0 00 0 01 02 33 1 1 a3 b3 14 2 1 a3 b3
D 1 410 33 0 00 0 01 02 34 1 1 a4 b4 15 0 1 a4 b4
D 1 414 33 0 00 0 01 02 35 1 1 a5 b5 16 1 1 a5 b5
D 1 418 33 0 00 0 01 02 36 1 1 a6 b6 17 2 1 a6 b6
D 1 41c 33 0 00 0 01 02 37 1 1 a7 b7 18 0 1 a7 b7
D 1 420 33 0 00 0 01 02 38 1 1 a8 b8 19 1 1 a8 b8
D 1 424 33 0 00 0 01 02 39 1 1 a9 b9 1a 2 1 a9 b9
D 1 428 33 0 00 0 01 02 3a 1 1 aa ba 1b 0 1 aa ba
D 1 42c 33 0 00 0 01 02 3b 1 1 ab bb 1c 1 1 ab bb
D 1 430 33 0 00 0 01 02 3c 1 1 ac bc 1d 2 1 ac bc
D 1 434 33 0 00 0 01 02 3d 1 1 ad bd 1e 0 1 ad bd
D 1 438 33 0 00 0 01 02 3e 1 1 ae be 1f 1 1 ae be
D 1 43c 33 0 00 0 01 02 3f 1 1 af bf 20 2 1 af bf
S 1
D 0 440 33 0 00 0 01 02 3f 1 1 ee ff 00 0 0 0 0
A 7
W 5
# test 6 broadcast in the dispatch cycle
B 2a 5a5a
D 1 500 33 0 00 0 2a 2b 2c 0 1 0 3 21 0 1 5a5a 3
W 6

/* src.f */
common/uiq_isa_pkg.sv
common/uiq_cfg_pkg.sv
source/optype_decoder.sv
source/tag_allocator.sv
issue_queue/iq_entry_array.sv
issue_queue/issue_select.sv
source/unified_issue_queue.sv
bench/uiq_assertions.sv
bench/uiq_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, then look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module uiq_tb \
    -f src.f -o uiq_sim > build.log 2>&1 \
    || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/uiq_sim > sim.log 2>&1
cat sim.log

grep -q "^PASS: all tests$" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* bench/uiq_tb.sv */
`timescale 1ns/100ps

module uiq_tb;
    import uiq_cfg_pkg::*;
    import uiq_isa_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int DRAIN_LIMIT = 200;
    localparam int STALL_LIMIT = 50;

    logic                   clk;
    logic                   rstn;
    logic                   dispatch_valid;
    xlen_t                  pc;
    logic     [6:0]         opcode;
    logic     [2:0]         funct3;
    logic     [6:0]         funct7;
    xlen_t                  imm;
    preg_t                  src1_preg;
    preg_t                  src2_preg;
    preg_t                  dest_preg;
    logic                   src1_ready;
    logic                   src2_ready;
    xlen_t                  src1_data;
    xlen_t                  src2_data;
    logic                   wb_valid;
    preg_t                  wb_preg;
    xlen_t                  wb_data;
    logic     [NUM_ALU-1:0] alu_ready;
    logic                   stall_out;
    logic                   dispatch_accept;
    logic     [NUM_ALU-1:0] issue_valid;
    xlen_t    [NUM_ALU-1:0] issue_pc;
    op_type_e [NUM_ALU-1:0] issue_op;
    xlen_t    [NUM_ALU-1:0] issue_src1_data;
    xlen_t    [NUM_ALU-1:0] issue_src2_data;
    xlen_t    [NUM_ALU-1:0] issue_imm;
    preg_t    [NUM_ALU-1:0] issue_dest;
    rob_tag_t [NUM_ALU-1:0] issue_rob_tag;

    // expected issue records, filed by rob tag.
    logic     exp_pending [ROB_SIZE];
    xlen_t    exp_pc      [ROB_SIZE];
    xlen_t    exp_imm     [ROB_SIZE];
    alu_id_t  exp_alu     [ROB_SIZE];
    op_type_e exp_op      [ROB_SIZE];
    xlen_t    exp_src1    [ROB_SIZE];
    xlen_t    exp_src2    [ROB_SIZE];
    preg_t    exp_dest    [ROB_SIZE];

    int pending;
    int errors;
    int checks;
    int tests;
    int errors_before;
    int fd;

    unified_issue_queue #(
        .IQ_DEPTH(IQ_DEPTH),
        .NUM_ALU (NUM_ALU),
        .ROB_SIZE(ROB_SIZE)
    ) unified_issue_queue_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_op(input op_type_e got, input op_type_e exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s op %s, expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_word(input xlen_t got, input xlen_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_tag(input rob_tag_t got, input rob_tag_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s rob tag %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_alu(input alu_id_t got, input alu_id_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s came out on alu %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_preg(input preg_t got, input preg_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s dest preg %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // one issue record against the table.
    task automatic take_issue(input int a);
        rob_tag_t tag;
        int       owner;
        string    what;
        tag   = issue_rob_tag[a];
        what  = $sformatf("issue pc %h", issue_pc[a]);
        owner = int'(tag);
        if (!exp_pending[tag]) begin
            // a wrong tag shows up as a record waiting under another tag.
            owner = -1;
            for (int t = 0; t < ROB_SIZE; t++) begin
                if (exp_pending[t] && exp_pc[t] == issue_pc[a]) begin
                    owner = t;
                end
            end
            if (owner < 0) begin
                errors++;
                $display("alu %0d issued tag %0d at %0t, but no instruction was waiting for it",
                         a, tag, $time);
                return;
            end
            check_tag(tag, rob_tag_t'(owner), what);
        end
        check_alu(alu_id_t'(a), exp_alu[owner], what);
        check_op(issue_op[a], exp_op[owner], what);
        check_word(issue_pc[a], exp_pc[owner], {what, " pc"});
        check_word(issue_imm[a], exp_imm[owner], {what, " imm"});
        check_word(issue_src1_data[a], exp_src1[owner], {what, " src1"});
        check_word(issue_src2_data[a], exp_src2[owner], {what, " src2"});
        check_preg(issue_dest[a], exp_dest[owner], what);
        exp_pending[owner] = 1'b0;
        pending--;
    endtask

    // issue outputs are registered, so look at them well after the edge.
    always begin
        @(posedge clk);
        #(CLK_PERIOD / 4);
        for (int a = 0; a < NUM_ALU; a++) begin
            if (rstn && issue_valid[a]) begin
                take_issue(a);
            end
        end
    end

    task automatic next_cycle();
        @(negedge clk);
        dispatch_valid = 1'b0;
        wb_valid       = 1'b0;
    endtask

    task automatic run_dispatch();
        logic [31:0] f [18];
        int          got;
        rob_tag_t    tag;
        for (int k = 0; k < 18; k++) begin
            got = $fscanf(fd, "%h", f[k]);
        end
        pc             = f[1];
        opcode         = f[2][6:0];
        funct3         = f[3][2:0];
        funct7         = f[4][6:0];
        imm            = f[5];
        src1_preg      = f[6][5:0];
        src2_preg      = f[7][5:0];
        dest_preg      = f[8][5:0];
        src1_ready     = f[9][0];
        src2_ready     = f[10][0];
        src1_data      = f[11];
        src2_data      = f[12];
        dispatch_valid = 1'b1;
        #(CLK_PERIOD / 4);
        checks++;
        if (dispatch_accept !== f[0][0]) begin
            errors++;
            $display("[ERROR] %0t: dispatch pc %h accept is %b, expected %b",
                     $time, f[1], dispatch_accept, f[0][0]);
        end
        if (dispatch_accept && f[0][0]) begin
            tag              = f[13][5:0];
            exp_pending[tag] = 1'b1;
            exp_pc[tag]      = f[1];
            exp_imm[tag]     = f[5];
            exp_dest[tag]    = f[8][5:0];
            exp_alu[tag]     = f[14][1:0];
            exp_op[tag]      = op_type_e'(f[15][3:0]);
            exp_src1[tag]    = f[16];
            exp_src2[tag]    = f[17];
            pending++;
        end
        next_cycle();
    endtask

    task automatic idle_cycles(input int cycles, input int expect_pending);
        for (int c = 0; c < cycles; c++) begin
            next_cycle();
        end
        checks++;
        if (pending != expect_pending) begin
            errors++;
            $display("[ERROR] %0t: %0d instructions still waiting, expected %0d",
                     $time, pending, expect_pending);
        end
    endtask

    task automatic wait_stall(input logic level);
        int c;
        c = 0;
        next_cycle();
        while (stall_out !== level && c < STALL_LIMIT) begin
            next_cycle();
            c++;
        end
        if (stall_out !== level) begin
            errors++;
            $display("gave up after %0d cycles waiting for stall_out to go %b", c, level);
        end
    endtask

    task automatic drain_and_report(input int num);
        int c;
        c = 0;
        next_cycle();
        while (pending != 0 && c < DRAIN_LIMIT) begin
            next_cycle();
            c++;
        end
        if (pending != 0) begin
            errors++;
            $display("test %0d timed out with %0d instructions never issued", num, pending);
            for (int t = 0; t < ROB_SIZE; t++) begin
                exp_pending[t] = 1'b0;
            end
            pending = 0;
        end
        // one quiet cycle catches a repeated issue.
        next_cycle();
        checks++;
        if (stall_out !== 1'b0) begin
            errors++;
            $display("[ERROR] %0t: stall_out still high with the queue drained", $time);
        end
        tests++;
        if (errors == errors_before) begin
            $display("test %0d passed", num);
        end else begin
            $display("test %0d failed with %0d errors", num, errors - errors_before);
        end
        errors_before = errors;
    endtask

    initial begin
        string       cmd;
        string       rest;
        logic [31:0] arg0;
        logic [31:0] arg1;
        int          n;
        int          got;
        rstn           = 1'b0;
        dispatch_valid = 1'b0;
        pc             = '0;
        opcode         = '0;
        funct3         = '0;
        funct7         = '0;
        imm            = '0;
        src1_preg      = '0;
        src2_preg      = '0;
        dest_preg      = '0;
        src1_ready     = 1'b0;
        src2_ready     = 1'b0;
        src1_data      = '0;
        src2_data      = '0;
        wb_valid       = 1'b0;
        wb_preg        = '0;
        wb_data        = '0;
        alu_ready      = '0;
        pending        = 0;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        errors_before  = 0;
        for (int t = 0; t < ROB_SIZE; t++) begin
            exp_pending[t] = 1'b0;
        end
        fd = $fopen("bench/uiq_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/uiq_golden.txt for reading");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            repeat (4) @(posedge clk);
            @(negedge clk);
            rstn = 1'b1;
            n = $fscanf(fd, "%s", cmd);
            while (n == 1) begin
                if (cmd == "D") begin
                    run_dispatch();
                end else if (cmd == "B") begin
                    // held for the cycle of the next command.
                    got      = $fscanf(fd, "%h %h", arg0, arg1);
                    wb_preg  = arg0[5:0];
                    wb_data  = arg1;
                    wb_valid = 1'b1;
                end else if (cmd == "A") begin
                    got       = $fscanf(fd, "%h", arg0);
                    alu_ready = arg0[NUM_ALU-1:0];
                end else if (cmd == "I") begin
                    got = $fscanf(fd, "%h %h", arg0, arg1);
                    idle_cycles(int'(arg0), int'(arg1));
                end else if (cmd == "S") begin
                    got = $fscanf(fd, "%h", arg0);
                    wait_stall(arg0[0]);
                end else if (cmd == "W") begin
                    got = $fscanf(fd, "%h", arg0);
                    drain_and_report(int'(arg0));
                end else begin
                    if (cmd.substr(0, 0) != "#") begin
                        errors++;
                        $display("unknown command %s in the golden file", cmd);
                    end
                    got = $fgets(rest, fd);
                end
                n = $fscanf(fd, "%s", cmd);
            end
            $fclose(fd);
            $display("tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
            if (errors == 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
            $finish;
        end
    end

endmodule

/* bench/uiq_assertions.sv */
`timescale 1ns/100ps

module uiq_assertions #(
    parameter int NUM_ALU = uiq_cfg_pkg::NUM_ALU
) (
    input logic               clk,
    input logic               rstn,
    input logic               stall_out,
    input logic               dispatch_accept,
    input logic [NUM_ALU-1:0] alu_ready,
    input logic [NUM_ALU-1:0] issue_valid
);

    // first full cycle after reset release.
    reset_quiet: assert property (@(posedge clk)
        $rose(rstn) |=> (issue_valid == '0) && !stall_out)
        else $error("issue_valid or stall_out set in the first cycle after reset");

    // the queue only fills through an accepted dispatch.
    stall_rise_on_accept: assert property (@(posedge clk) disable iff (!rstn)
        $rose(stall_out) |-> $past(dispatch_accept))
        else $error("stall_out rose without an accepted dispatch before it");

    // issue registers load from the ready level of the cycle before.
    issue_needs_ready: assert property (@(posedge clk) disable iff (!rstn)
        (issue_valid & ~$past(alu_ready)) == '0)
        else $error("issue_valid on an alu whose alu_ready was low");

endmodule

bind unified_issue_queue uiq_assertions #(
    .NUM_ALU(NUM_ALU)
) uiq_assertions_inst (
    .clk            (clk),
    .rstn           (rstn),
    .stall_out      (stall_out),
    .dispatch_accept(dispatch_accept),
    .alu_ready      (alu_ready),
    .issue_valid    (issue_valid)
);

/* source/unified_issue_queue.sv */
`timescale 1ns/100ps

module unified_issue_queue #(
    parameter int IQ_DEPTH = uiq_cfg_pkg::IQ_DEPTH,
    parameter int NUM_ALU  = uiq_cfg_pkg::NUM_ALU,
    parameter int ROB_SIZE = uiq_cfg_pkg::ROB_SIZE
) (
    input  logic                                     clk,
    input  logic                                     rstn,
    input  logic                                     dispatch_valid,
    input  uiq_cfg_pkg::xlen_t                       pc,
    input  logic                       [6:0]         opcode,
    input  logic                       [2:0]         funct3,
    input  logic                       [6:0]         funct7,
    input  uiq_cfg_pkg::xlen_t                       imm,
    input  uiq_cfg_pkg::preg_t                       src1_preg,
    input  uiq_cfg_pkg::preg_t                       src2_preg,
    input  uiq_cfg_pkg::preg_t                       dest_preg,
    input  logic                                     src1_ready,
    input  logic                                     src2_ready,
    input  uiq_cfg_pkg::xlen_t                       src1_data,
    input  uiq_cfg_pkg::xlen_t                       src2_data,
    input  logic                                     wb_valid,
    input  uiq_cfg_pkg::preg_t                       wb_preg,
    input  uiq_cfg_pkg::xlen_t                       wb_data,
    input  logic                       [NUM_ALU-1:0] alu_ready,
    output logic                                     stall_out,
    output logic                                     dispatch_accept,
    output logic                       [NUM_ALU-1:0] issue_valid,
    output uiq_cfg_pkg::xlen_t         [NUM_ALU-1:0] issue_pc,
    output uiq_isa_pkg::op_type_e      [NUM_ALU-1:0] issue_op,
    output uiq_cfg_pkg::xlen_t         [NUM_ALU-1:0] issue_src1_data,
    output uiq_cfg_pkg::xlen_t         [NUM_ALU-1:0] issue_src2_data,
    output uiq_cfg_pkg::xlen_t         [NUM_ALU-1:0] issue_imm,
    output uiq_cfg_pkg::preg_t         [NUM_ALU-1:0] issue_dest,
    output uiq_cfg_pkg::rob_tag_t      [NUM_ALU-1:0] issue_rob_tag
);
    import uiq_cfg_pkg::*;
    import uiq_isa_pkg::*;

    op_type_e op_type;
    logic     src1_implied;
    logic     src2_implied;
    alu_id_t  alu_num;
    rob_tag_t rob_tag;

    // entry state seen by the select.
    logic     [IQ_DEPTH-1:0] entry_ready;
    logic     [IQ_DEPTH-1:0] issue_clear;
    op_type_e [IQ_DEPTH-1:0] entry_op;
    xlen_t    [IQ_DEPTH-1:0] entry_pc;
    xlen_t    [IQ_DEPTH-1:0] entry_imm;
    xlen_t    [IQ_DEPTH-1:0] entry_src1_data;
    xlen_t    [IQ_DEPTH-1:0] entry_src2_data;
    preg_t    [IQ_DEPTH-1:0] entry_dest;
    rob_tag_t [IQ_DEPTH-1:0] entry_rob_tag;
    alu_id_t  [IQ_DEPTH-1:0] entry_alu;

    optype_decoder optype_decoder_inst (.*);

    // counters move only when the array takes the instruction.
    tag_allocator #(
        .NUM_ALU (NUM_ALU),
        .ROB_SIZE(ROB_SIZE)
    ) tag_allocator_inst (
        .advance(dispatch_accept),
        .*
    );

    iq_entry_array #(
        .IQ_DEPTH(IQ_DEPTH)
    ) iq_entry_array_inst (
        .accept(dispatch_accept),
        .stall (stall_out),
        .*
    );

    issue_select #(
        .IQ_DEPTH(IQ_DEPTH),
        .NUM_ALU (NUM_ALU)
    ) issue_select_inst (.*);

endmodule

/* issue_queue/issue_select.sv */
`timescale 1ns/100ps

module issue_select #(
    parameter int IQ_DEPTH = uiq_cfg_pkg::IQ_DEPTH,
    parameter int NUM_ALU  = uiq_cfg_pkg::NUM_ALU
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic                       [IQ_DEPTH-1:0] entry_ready,
    input  uiq_isa_pkg::op_type_e      [IQ_DEPTH-1:0] entry_op,
    input  uiq_cfg_pkg::xlen_t         [IQ_DEPTH-1:0] entry_pc,
    input  uiq_cfg_pkg::xlen_t         [IQ_DEPTH-1:0] entry_imm,
    input  uiq_cfg_pkg::xlen_t         [IQ_DEPTH-1:0] entry_src1_data,
    input  uiq_cfg_pkg::xlen_t         [IQ_DEPTH-1:0] entry_src2_data,
    input  uiq_cfg_pkg::preg_t         [IQ_DEPTH-1:0] entry_dest,
    input  uiq_cfg_pkg::rob_tag_t      [IQ_DEPTH-1:0] entry_rob_tag,
    input  uiq_cfg_pkg::alu_id_t       [IQ_DEPTH-1:0] entry_alu,
    input  logic                       [NUM_ALU-1:0]  alu_ready,
    output logic                       [IQ_DEPTH-1:0] issue_clear,
    output logic                       [NUM_ALU-1:0]  issue_valid,
    output uiq_cfg_pkg::xlen_t         [NUM_ALU-1:0]  issue_pc,
    output uiq_isa_pkg::op_type_e      [NUM_ALU-1:0]  issue_op,
    output uiq_cfg_pkg::xlen_t         [NUM_ALU-1:0]  issue_src1_data,
    output uiq_cfg_pkg::xlen_t         [NUM_ALU-1:0]  issue_src2_data,
    output uiq_cfg_pkg::xlen_t         [NUM_ALU-1:0]  issue_imm,
    output uiq_cfg_pkg::preg_t         [NUM_ALU-1:0]  issue_dest,
    output uiq_cfg_pkg::rob_tag_t      [NUM_ALU-1:0]  issue_rob_tag
);
    import uiq_cfg_pkg::*;

    localparam int IDX_W = $clog2(IQ_DEPTH);

    logic [NUM_ALU-1:0] pick_found;
    logic [IDX_W-1:0]   pick_idx [NUM_ALU];

    // one pick per ready alu, lowest index wins.
    always_comb begin
        pick_found  = '0;
        issue_clear = '0;
        for (int a = 0; a < NUM_ALU; a++) begin
            pick_idx[a] = '0;
            for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
                if (alu_ready[a] && entry_ready[i] && entry_alu[i] == alu_id_t'(a)) begin
                    pick_found[a] = 1'b1;
                    pick_idx[a]   = IDX_W'(i);
                end
            end
            // freed at the same edge that loads the issue registers.
            if (pick_found[a]) begin
                issue_clear[pick_idx[a]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            issue_valid <= '0;
        end else begin
            issue_valid <= pick_found;
        end
    end

    // payload only loads on a pick, valid marks it.
    always_ff @(posedge clk) begin
        for (int a = 0; a < NUM_ALU; a++) begin
            if (pick_found[a]) begin
                issue_pc[a]        <= entry_pc[pick_idx[a]];
                issue_op[a]        <= entry_op[pick_idx[a]];
                issue_src1_data[a] <= entry_src1_data[pick_idx[a]];
                issue_src2_data[a] <= entry_src2_data[pick_idx[a]];
                issue_imm[a]       <= entry_imm[pick_idx[a]];
                issue_dest[a]      <= entry_dest[pick_idx[a]];
                issue_rob_tag[a]   <= entry_rob_tag[pick_idx[a]];
            end
        end
    end

endmodule

/* issue_queue/iq_entry_array.sv */
`timescale 1ns/100ps

module iq_entry_array #(
    parameter int IQ_DEPTH = uiq_cfg_pkg::IQ_DEPTH
) (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic                                      dispatch_valid,
    input  uiq_isa_pkg::op_type_e                     op_type,
    input  logic                                      src1_implied,
    input  logic                                      src2_implied,
    input  uiq_cfg_pkg::xlen_t                        pc,
    input  uiq_cfg_pkg::xlen_t                        imm,
    input  uiq_cfg_pkg::preg_t                        src1_preg,
    input  uiq_cfg_pkg::preg_t                        src2_preg,
    input  uiq_cfg_pkg::preg_t                        dest_preg,
    input  logic                                      src1_ready,
    input  logic                                      src2_ready,
    input  uiq_cfg_pkg::xlen_t                        src1_data,
    input  uiq_cfg_pkg::xlen_t                        src2_data,
    input  uiq_cfg_pkg::alu_id_t                      alu_num,
    input  uiq_cfg_pkg::rob_tag_t                     rob_tag,
    input  logic                                      wb_valid,
    input  uiq_cfg_pkg::preg_t                        wb_preg,
    input  uiq_cfg_pkg::xlen_t                        wb_data,
    input  logic                       [IQ_DEPTH-1:0] issue_clear,
    output logic                                      accept,
    output logic                                      stall,
    output logic                       [IQ_DEPTH-1:0] entry_ready,
    output uiq_isa_pkg::op_type_e      [IQ_DEPTH-1:0] entry_op,
    output uiq_cfg_pkg::xlen_t         [IQ_DEPTH-1:0] entry_pc,
    output uiq_cfg_pkg::xlen_t         [IQ_DEPTH-1:0] entry_imm,
    output uiq_cfg_pkg::xlen_t         [IQ_DEPTH-1:0] entry_src1_data,
    output uiq_cfg_pkg::xlen_t         [IQ_DEPTH-1:0] entry_src2_data,
    output uiq_cfg_pkg::preg_t         [IQ_DEPTH-1:0] entry_dest,
    output uiq_cfg_pkg::rob_tag_t      [IQ_DEPTH-1:0] entry_rob_tag,
    output uiq_cfg_pkg::alu_id_t       [IQ_DEPTH-1:0] entry_alu
);
    import uiq_cfg_pkg::*;
    import uiq_isa_pkg::*;

    localparam int IDX_W = $clog2(IQ_DEPTH);
    localparam int CNT_W = $clog2(IQ_DEPTH + 1);

    logic  [IQ_DEPTH-1:0] valid;
    logic  [IQ_DEPTH-1:0] src1_rdy;
    logic  [IQ_DEPTH-1:0] src2_rdy;
    preg_t [IQ_DEPTH-1:0] src1_tag;
    preg_t [IQ_DEPTH-1:0] src2_tag;

    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic [IDX_W-1:0] free_idx;

    logic  new_src1_rdy;
    logic  new_src2_rdy;
    xlen_t new_src1_data;
    xlen_t new_src2_data;

    // stall is registered, so a full queue can never take a dispatch.
    assign accept = dispatch_valid && !stall && (op_type != OP_NONE);

    // downward scan leaves the lowest free index.
    always_comb begin
        free_idx = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    // implied operand first, then dispatch, then same-cycle broadcast.
    assign new_src1_rdy  = src1_implied || src1_ready || (wb_valid && wb_preg == src1_preg);
    assign new_src2_rdy  = src2_implied || src2_ready || (wb_valid && wb_preg == src2_preg);
    assign new_src1_data = src1_implied ? '0 : (src1_ready ? src1_data : wb_data);
    assign new_src2_data = src2_implied ? '0 : (src2_ready ? src2_data : wb_data);

    assign count_next  = count + CNT_W'(accept) - CNT_W'($countones(issue_clear));
    assign entry_ready = valid & src1_rdy & src2_rdy;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
            count <= '0;
            stall <= 1'b0;
        end else begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (issue_clear[i]) begin
                    valid[i] <= 1'b0;
                end
            end
            if (accept) begin
                valid[free_idx] <= 1'b1;
            end
            count <= count_next;
            stall <= (count_next == CNT_W'(IQ_DEPTH));
        end
    end

    always_ff @(posedge clk) begin
        // wakeup of waiting sources.
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (valid[i] && wb_valid) begin
                if (!src1_rdy[i] && src1_tag[i] == wb_preg) begin
                    src1_rdy[i]        <= 1'b1;
                    entry_src1_data[i] <= wb_data;
                end
                if (!src2_rdy[i] && src2_tag[i] == wb_preg) begin
                    src2_rdy[i]        <= 1'b1;
                    entry_src2_data[i] <= wb_data;
                end
            end
        end
        if (accept) begin
            entry_op[free_idx]        <= op_type;
            entry_pc[free_idx]        <= pc;
            entry_imm[free_idx]       <= imm;
            entry_dest[free_idx]      <= dest_preg;
            entry_rob_tag[free_idx]   <= rob_tag;
            entry_alu[free_idx]       <= alu_num;
            src1_tag[free_idx]        <= src1_preg;
            src2_tag[free_idx]        <= src2_preg;
            src1_rdy[free_idx]        <= new_src1_rdy;
            src2_rdy[free_idx]        <= new_src2_rdy;
            entry_src1_data[free_idx] <= new_src1_data;
            entry_src2_data[free_idx] <= new_src2_data;
        end
    end

endmodule

/* source/tag_allocator.sv */
`timescale 1ns/100ps

module tag_allocator #(
    parameter int NUM_ALU  = uiq_cfg_pkg::NUM_ALU,
    parameter int ROB_SIZE = uiq_cfg_pkg::ROB_SIZE
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  advance,
    output uiq_cfg_pkg::alu_id_t  alu_num,
    output uiq_cfg_pkg::rob_tag_t rob_tag
);
    import uiq_cfg_pkg::*;

    // both counters step together, once per accepted dispatch.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            alu_num <= '0;
            rob_tag <= '0;
        end else if (advance) begin
            if (alu_num == alu_id_t'(NUM_ALU - 1)) begin
                alu_num <= '0;
            end else begin
                alu_num <= alu_num + 1'b1;
            end
            // rob tag wraps at the rob size.
            if (rob_tag == rob_tag_t'(ROB_SIZE - 1)) begin
                rob_tag <= '0;
            end else begin
                rob_tag <= rob_tag + 1'b1;
            end
        end
    end

endmodule

/* source/optype_decoder.sv */
`timescale 1ns/100ps

module optype_decoder (
    input  logic                  [6:0] opcode,
    input  logic                  [2:0] funct3,
    input  logic                  [6:0] funct7,
    output uiq_isa_pkg::op_type_e       op_type,
    output logic                        src1_implied,
    output logic                        src2_implied
);
    import uiq_isa_pkg::*;

    always_comb begin
        op_type = OP_NONE;
        case (opcode)
            OPC_RTYPE: begin
                // only the base funct7 forms are handled.
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        F3_ADD:  op_type = OP_ADD;
                        F3_XOR:  op_type = OP_XOR;
                        default: op_type = OP_NONE;
                    endcase
                end
            end
            OPC_ITYPE: begin
                case (funct3)
                    F3_ADD:  op_type = OP_ADDI;
                    F3_SRA:  op_type = OP_SRAI;
                    F3_OR:   op_type = OP_ORI;
                    default: op_type = OP_NONE;
                endcase
            end
            OPC_LUI: op_type = OP_LUI;
            OPC_LOAD: begin
                case (funct3)
                    F3_BYTE: op_type = OP_LB;
                    F3_WORD: op_type = OP_LW;
                    default: op_type = OP_NONE;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    F3_BYTE: op_type = OP_SB;
                    F3_WORD: op_type = OP_SW;
                    default: op_type = OP_NONE;
                endcase
            end
            default: op_type = OP_NONE;
        endcase
    end

    // operands the instruction never reads, they are taken as zero.
    assign src1_implied = (op_type == OP_LUI);
    assign src2_implied = op_type inside {OP_LUI, OP_ADDI, OP_ORI, OP_SRAI, OP_LB, OP_LW};

endmodule

/* common/uiq_cfg_pkg.sv */
package uiq_cfg_pkg;

    // field widths.
    localparam int XLEN      = 32;
    localparam int PREG_W    = 6;
    localparam int ROB_TAG_W = 6;
    localparam int ALU_ID_W  = 2;

    // default sizes, the top level may override them.
    localparam int IQ_DEPTH = 16;
    localparam int NUM_ALU  = 3;
    localparam int ROB_SIZE = 64;

    // data, pc and immediate word.
    typedef logic [XLEN-1:0] xlen_t;

    // physical register number, 64 registers.
    typedef logic [PREG_W-1:0] preg_t;

    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    typedef logic [ALU_ID_W-1:0] alu_id_t;

endpackage

/* common/uiq_isa_pkg.sv */
package uiq_isa_pkg;

    // major opcodes of the supported subset.
    localparam logic [6:0] OPC_RTYPE = 7'b0110011;
    localparam logic [6:0] OPC_ITYPE = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // funct3 codes for alu ops.
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRA = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;

    // funct3 codes for memory access size.
    localparam logic [2:0] F3_BYTE = 3'b000;
    localparam logic [2:0] F3_WORD = 3'b010;

    // base r-type forms, sub and friends use 0100000.
    localparam logic [6:0] F7_BASE = 7'b0000000;

    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_ADD  = 4'd1,
        OP_ADDI = 4'd2,
        OP_LUI  = 4'd3,
        OP_ORI  = 4'd4,
        OP_XOR  = 4'd5,
        OP_SRAI = 4'd6,
        OP_LB   = 4'd7,
        OP_LW   = 4'd8,
        OP_SB   = 4'd9,
        OP_SW   = 4'd10
    } op_type_e;

endpackage
